//--- list.f
+incdir+.
pcPkg.sv
jumpCtrlIf.sv
instrDecode.sv
branchCompare.sv
programCounter.sv
fetchControl.sv
fetchControl_properties.sv
fetchControl_tb.sv

//--- fetchControl_tb.sv
`timescale 1ns/1ps
`include "pc_cfg.svh"

module fetchControl_tb;
  import pcPkg::*;

  localparam int clkPeriod = 8;
  localparam int numRows = 26;
  localparam int numRandom = 40;
  // addi x0, x0, 0
  localparam logic [31:0] plainWord = 32'h0000_0013;

  // one step of stimulus plus what should show up after the next rising edge
  typedef struct packed {
    instr_u instr;
    addr_t  rs1;
    addr_t  rs2;
    logic   enable;
    addr_t  expAddress;
    addr_t  expLink;
    logic   expValid;
  } stepRow_t;

  logic        clk;
  logic        arstN;
  logic        enable;
  logic [31:0] instruction;
  logic [31:0] rs1Value;
  logic [31:0] rs2Value;
  logic [31:0] instructionAddress;
  logic [31:0] linkAddress;
  logic        linkValid;

  stepRow_t    rows[$];
  string       rowNames[$];
  logic [31:0] lfsrState;

  fetchControl DUT (
    .clk                (clk),
    .arstN              (arstN),
    .enable             (enable),
    .instruction        (instruction),
    .rs1Value           (rs1Value),
    .rs2Value           (rs2Value),
    .instructionAddress (instructionAddress),
    .linkAddress        (linkAddress),
    .linkValid          (linkValid)
  );

  bind programCounter fetchControl_properties props (
    .clk                (clk),
    .arstN              (arstN),
    .enable             (enable),
    .instructionAddress (instructionAddress),
    .linkAddress        (linkAddress),
    .linkValid          (linkValid)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // one cycle per row and per random step plus slack for reset
  initial begin
    #((numRows + numRandom + 10) * clkPeriod);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic randomBits(input int count, output logic [31:0] value);
    value = '0;
    for (int k = 0; k < count; k++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  // encoders scatter the offset over the isa fields
  function automatic instr_u jalWord(input addr_t offset);
    instr_u ins;
    ins.raw = '0;
    ins.jType.imm20 = offset[20];
    ins.jType.imm19_12 = offset[19:12];
    ins.jType.imm11 = offset[11];
    ins.jType.imm10_1 = offset[10:1];
    ins.jType.rd = 5'd1;
    ins.jType.opcode = JAL;
    return ins;
  endfunction

  function automatic instr_u jalrWord(input addr_t offset);
    instr_u ins;
    ins.raw = '0;
    ins.iType.imm11_0 = offset[11:0];
    ins.iType.rd = 5'd1;
    ins.iType.opcode = JALR;
    return ins;
  endfunction

  // funct left as raw bits so reserved codes fit
  function automatic instr_u branchWord(input logic [2:0] funct, input addr_t offset);
    instr_u ins;
    ins.raw = '0;
    ins.bType.imm12 = offset[12];
    ins.bType.imm11 = offset[11];
    ins.bType.imm10_5 = offset[10:5];
    ins.bType.imm4_1 = offset[4:1];
    ins.bType.rs1 = 5'd1;
    ins.bType.rs2 = 5'd2;
    ins.bType.funct3 = funct;
    ins.bType.opcode = BRANCH;
    return ins;
  endfunction

  // reference condition straight from the isa rules
  function automatic logic branchTaken(input logic [2:0] funct, input addr_t a, input addr_t b);
    case (funct)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic addRow(input string name, input instr_u ins, input addr_t rs1, input addr_t rs2,
                        input logic en, input addr_t expAddress, input addr_t expLink,
                        input logic expValid);
    rows.push_back({ins, rs1, rs2, en, expAddress, expLink, expValid});
    rowNames.push_back(name);
  endtask

  task automatic checkAddress(input string testName, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("Error %s: address expected %h, actual %h", testName, expected, actual);
      $display("Test failures found");
      $fatal(1, "instruction address mismatch");
    end
  endtask

  task automatic checkLink(input string testName, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("Error %s: link expected %h, actual %h", testName, expected, actual);
      $display("Test failures found");
      $fatal(1, "link address mismatch");
    end
  endtask

  task automatic checkFlag(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error %s: linkValid expected %b, actual %b", testName, expected, actual);
      $display("Test failures found");
      $fatal(1, "link valid mismatch");
    end
  endtask

  initial begin
    stepRow_t    row;
    addr_t       expAddress;
    addr_t       offset;
    addr_t       a;
    addr_t       b;
    logic [31:0] bits;
    logic [2:0]  funct;
    arstN = 1'b1;
    enable = 1'b0;
    instruction = plainWord;
    rs1Value = '0;
    rs2Value = '0;
    lfsrState = 32'hfd0881a6;
    // hold, step, jal, jalr
    addRow("hold 0", instr_u'(plainWord), 0, 0, 0, 32'h0, 0, 0);
    addRow("hold 1", instr_u'(plainWord), 0, 0, 0, 32'h0, 0, 0);
    addRow("hold 2", instr_u'(plainWord), 0, 0, 0, 32'h0, 0, 0);
    addRow("step 4", instr_u'(plainWord), 0, 0, 1, 32'h4, 0, 0);
    addRow("step 8", instr_u'(plainWord), 0, 0, 1, 32'h8, 0, 0);
    addRow("step c", instr_u'(plainWord), 0, 0, 1, 32'hc, 0, 0);
    addRow("jal fwd", jalWord(32'h100), 0, 0, 1, 32'h10c, 32'h10, 1);
    addRow("step after jal", instr_u'(plainWord), 0, 0, 1, 32'h110, 0, 0);
    addRow("jal back", jalWord(-16), 0, 0, 1, 32'h100, 32'h114, 1);
    addRow("jalr pos", jalrWord(32'h10), 32'h2001, 0, 1, 32'h2010, 32'h104, 1);
    addRow("jalr neg", jalrWord(-3), 32'h3000, 0, 1, 32'h2ffc, 32'h2014, 1);
    // branches with signed and unsigned boundary pairs
    addRow("beq taken", branchWord(BEQ, 32'h20), 5, 5, 1, 32'h301c, 0, 0);
    addRow("beq not", branchWord(BEQ, 32'h20), 5, 6, 1, 32'h3020, 0, 0);
    addRow("bne back", branchWord(BNE, -8), 5, 6, 1, 32'h3018, 0, 0);
    addRow("blt neg", branchWord(BLT, 32'h40), 32'hffffffff, 1, 1, 32'h3058, 0, 0);
    addRow("bltu big", branchWord(BLTU, 32'h40), 32'hffffffff, 1, 1, 32'h305c, 0, 0);
    addRow("bge min", branchWord(BGE, 32'h10), 32'h80000000, 32'h7fffffff, 1, 32'h3060, 0, 0);
    addRow("bgeu min", branchWord(BGEU, 32'h10), 32'h80000000, 32'h7fffffff, 1, 32'h3070, 0, 0);
    addRow("blt max", branchWord(BLT, 32'h10), 32'h7fffffff, 32'h80000000, 1, 32'h3074, 0, 0);
    addRow("bge equal", branchWord(BGE, 32'h8), 3, 3, 1, 32'h307c, 0, 0);
    addRow("bltu small", branchWord(BLTU, 32'hc), 0, 1, 1, 32'h3088, 0, 0);
    addRow("reserved 2", branchWord(3'd2, 32'h40), 1, 2, 1, 32'h308c, 0, 0);
    addRow("reserved 3", branchWord(3'd3, 32'h40), 5, 5, 1, 32'h3090, 0, 0);
    // enable low ignores a jump and drops the link
    addRow("jal disabled", jalWord(32'h40), 0, 0, 0, 32'h3090, 0, 0);
    addRow("jal short", jalWord(32'h8), 0, 0, 1, 32'h3098, 32'h3094, 1);
    addRow("link dropped", instr_u'(plainWord), 0, 0, 0, 32'h3098, 0, 0);
    #1 arstN = 1'b0;
    repeat (2) @(negedge clk);
    checkAddress("reset", `PC_RESET_VECTOR, instructionAddress);
    checkLink("reset", '0, linkAddress);
    checkFlag("reset", 1'b0, linkValid);
    arstN = 1'b1;
    foreach (rows[i]) begin
      row = rows[i];
      instruction = row.instr.raw;
      rs1Value = row.rs1;
      rs2Value = row.rs2;
      enable = row.enable;
      @(negedge clk);
      checkAddress(rowNames[i], row.expAddress, instructionAddress);
      checkLink(rowNames[i], row.expLink, linkAddress);
      checkFlag(rowNames[i], row.expValid, linkValid);
    end
    // random branches continue from the last table address
    expAddress = rows[rows.size() - 1].expAddress;
    enable = 1'b1;
    for (int i = 0; i < numRandom; i++) begin
      randomBits(3, bits);
      funct = bits[2:0];
      randomBits(32, a);
      randomBits(32, b);
      randomBits(1, bits);
      if (bits[0]) begin
        b = a;
      end
      randomBits(11, bits);
      offset = {{20{bits[10]}}, bits[10:0], 1'b0};
      instruction = branchWord(funct, offset);
      rs1Value = a;
      rs2Value = b;
      expAddress = branchTaken(funct, a, b) ? expAddress + offset : expAddress + 32'd4;
      @(negedge clk);
      checkAddress($sformatf("random %0d", i), expAddress, instructionAddress);
      checkLink($sformatf("random %0d", i), '0, linkAddress);
      checkFlag($sformatf("random %0d", i), 1'b0, linkValid);
    end
    if (DUT.PC.props.failCount != 0) begin
      $display("Concurrent assertions failed %0d times", DUT.PC.props.failCount);
      $display("Test failures found");
      $fatal(1, "assertion failure");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

//--- fetchControl_properties.sv
`timescale 1ns/1ps
`include "pc_cfg.svh"

module fetchControl_properties (
  input logic         clk,
  input logic         arstN,
  input logic         enable,
  input pcPkg::addr_t instructionAddress,
  input pcPkg::addr_t linkAddress,
  input logic         linkValid
);

  // failures seen so far
  int failCount = 0;

  // targets stay even since jalr clears bit 0
  addressEven: assert property (
    @(posedge clk) disable iff (!arstN) instructionAddress[0] == 1'b0
  ) else begin
    failCount++;
    $error("instruction address is odd: %h", instructionAddress);
  end

  // no step means no link on the following cycle
  linkClearedWhenIdle: assert property (
    @(posedge clk) disable iff (!arstN) !enable |=> (linkAddress == '0 && !linkValid)
  ) else begin
    failCount++;
    $error("link not cleared after a cycle with enable low");
  end

  // async reset holds the counter at the reset vector
  resetVector: assert property (
    @(posedge clk) !arstN |-> instructionAddress == `PC_RESET_VECTOR
  ) else begin
    failCount++;
    $error("address left the reset vector while in reset");
  end

endmodule

//--- fetchControl.sv
`timescale 1ns/1ps
`include "pc_cfg.svh"

module fetchControl (
  input  logic               clk,
  input  logic               arstN,
  input  logic               enable,
  input  logic [`PC_XLEN-1:0] instruction,
  input  logic [`PC_XLEN-1:0] rs1Value,
  input  logic [`PC_XLEN-1:0] rs2Value,
  output logic [`PC_XLEN-1:0] instructionAddress,
  output logic [`PC_XLEN-1:0] linkAddress,
  output logic               linkValid
);

  // decoded controls from decode to counter
  jumpCtrlIf ctrlBus ();

  logic condJumpValue;

  // opcode class and immediate
  instrDecode decode (
    .instruction (instruction),
    .ctrl        (ctrlBus.decode)
  );

  // branch condition, valid only while doCondJump is up
  branchCompare compare (
    .branchFunct   (ctrlBus.branchFunct),
    .rs1Value      (rs1Value),
    .rs2Value      (rs2Value),
    .condJumpValue (condJumpValue)
  );

  // address register, rs1 doubles as the jalr base
  programCounter PC (
    .clk                (clk),
    .arstN              (arstN),
    .enable             (enable),
    .ctrl               (ctrlBus.counter),
    .condJumpValue      (condJumpValue),
    .regJumpValue       (rs1Value),
    .instructionAddress (instructionAddress),
    .linkAddress        (linkAddress),
    .linkValid          (linkValid)
  );

endmodule

//--- programCounter.sv
`timescale 1ns/1ps
`include "pc_cfg.svh"

module programCounter (
  input  logic              clk,
  input  logic              arstN,
  input  logic              enable,
  jumpCtrlIf.counter        ctrl,
  input  logic              condJumpValue,
  input  pcPkg::addr_t      regJumpValue,
  output pcPkg::addr_t      instructionAddress,
  output pcPkg::addr_t      linkAddress,
  output logic              linkValid
);
  import pcPkg::*;

  addr_t seqAddress;
  addr_t relTarget;
  addr_t regTarget;
  addr_t nextAddress;

  // fall-through address, also the return address for jal/jalr
  assign seqAddress = instructionAddress + `PC_STEP;

  // pc-relative target for jal and taken branches
  assign relTarget = instructionAddress + ctrl.immValue;

  // jalr target, lsb forced low per the isa
  assign regTarget = (regJumpValue + ctrl.immValue) & ~addr_t'(1);

  always_comb begin
    if (ctrl.doForceJump) begin
      if (ctrl.doRegJump) begin
        nextAddress = regTarget;
      end else begin
        nextAddress = relTarget;
      end
    end else if (ctrl.doCondJump && condJumpValue) begin
      nextAddress = relTarget;
    end else begin
      nextAddress = seqAddress;
    end
  end

  // rising edge, inputs are set up on the falling edge
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instructionAddress <= `PC_RESET_VECTOR;
      linkAddress        <= '0;
      linkValid          <= 1'b0;
    end else if (enable) begin
      instructionAddress <= nextAddress;
      if (ctrl.doForceJump) begin
        linkAddress <= seqAddress;
        linkValid   <= 1'b1;
      end else begin
        linkAddress <= '0;
        linkValid   <= 1'b0;
      end
    end else begin
      // no step, address holds, link dropped
      linkAddress <= '0;
      linkValid   <= 1'b0;
    end
  end

endmodule

//--- branchCompare.sv
`timescale 1ns/1ps

module branchCompare (
  input  pcPkg::branchFunct_e branchFunct,
  input  pcPkg::addr_t        rs1Value,
  input  pcPkg::addr_t        rs2Value,
  output logic                condJumpValue
);
  import pcPkg::*;

  logic isEqual;
  logic isLessSigned;
  logic isLessUnsigned;

  // shared compare results, each condition is one of these or its inverse
  assign isEqual        = (rs1Value == rs2Value);
  assign isLessSigned   = ($signed(rs1Value) < $signed(rs2Value));
  assign isLessUnsigned = (rs1Value < rs2Value);

  // opcode not looked at here, counter gates with doCondJump
  always_comb begin
    case (branchFunct)
      BEQ: begin
        condJumpValue = isEqual;
      end
      BNE: begin
        condJumpValue = ~isEqual;
      end
      BLT: begin
        condJumpValue = isLessSigned;
      end
      BGE: begin
        condJumpValue = ~isLessSigned;
      end
      BLTU: begin
        condJumpValue = isLessUnsigned;
      end
      BGEU: begin
        condJumpValue = ~isLessUnsigned;
      end
      default: begin
        // codes 2 and 3 are reserved, never taken
        condJumpValue = 1'b0;
      end
    endcase
  end

endmodule

//--- instrDecode.sv
`timescale 1ns/1ps
`include "pc_cfg.svh"

module instrDecode (
  input pcPkg::instr_u instruction,
  jumpCtrlIf.decode    ctrl
);
  import pcPkg::*;

  opcode_e opcode;
  addr_t   iImm;
  addr_t   bImm;
  addr_t   jImm;

  // opcode sits in the same bits for every format
  assign opcode = opcode_e'(instruction.raw[6:0]);

  // jalr offset, 12 bits signed
  assign iImm = {{(`PC_XLEN-12){instruction.iType.imm11_0[11]}},
                 instruction.iType.imm11_0};

  // branch offset, always even so bit 0 is implied
  assign bImm = {{(`PC_XLEN-13){instruction.bType.imm12}},
                 instruction.bType.imm12,
                 instruction.bType.imm11,
                 instruction.bType.imm10_5,
                 instruction.bType.imm4_1,
                 1'b0};

  // jal offset, +-1 MiB range
  assign jImm = {{(`PC_XLEN-21){instruction.jType.imm20}},
                 instruction.jType.imm20,
                 instruction.jType.imm19_12,
                 instruction.jType.imm11,
                 instruction.jType.imm10_1,
                 1'b0};

  // funct3 passed through untouched, reserved codes included
  assign ctrl.branchFunct = branchFunct_e'(instruction.bType.funct3);

  always_comb begin
    // nothing raised unless a control-flow opcode shows up
    ctrl.doForceJump = 1'b0;
    ctrl.doCondJump  = 1'b0;
    ctrl.doRegJump   = 1'b0;
    ctrl.immValue    = '0;
    case (opcode)
      JAL: begin
        ctrl.doForceJump = 1'b1;
        ctrl.immValue    = jImm;
      end
      JALR: begin
        // jump through rs1
        ctrl.doForceJump = 1'b1;
        ctrl.doRegJump   = 1'b1;
        ctrl.immValue    = iImm;
      end
      BRANCH: begin
        ctrl.doCondJump = 1'b1;
        ctrl.immValue   = bImm;
      end
      default: begin
        // plain step, defaults hold
        ctrl.immValue = '0;
      end
    endcase
  end

endmodule

//--- jumpCtrlIf.sv
`timescale 1ns/1ps

interface jumpCtrlIf;
  import pcPkg::*;

  // unconditional jump, jal or jalr
  logic doForceJump;
  // branch group, taken only when the compare says so
  logic doCondJump;
  // target based on rs1 instead of the current address
  logic doRegJump;
  // sign-extended immediate of the decoded format
  addr_t immValue;
  // branch condition select, goes to the comparator
  branchFunct_e branchFunct;

  // decode side drives everything
  modport decode (
    output doForceJump,
    output doCondJump,
    output doRegJump,
    output immValue,
    output branchFunct
  );

  // counter side, no need for the condition select
  modport counter (
    input doForceJump,
    input doCondJump,
    input doRegJump,
    input immValue
  );

endinterface

//--- pcPkg.sv
`include "pc_cfg.svh"

package pcPkg;

  // address or register data word
  typedef logic [`PC_XLEN-1:0] addr_t;

  // only the control-flow opcodes matter here
  typedef enum logic [6:0] {
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    // any non control-flow opcode, op-imm used as the stand-in
    OTHER  = 7'b0010011
  } opcode_e;

  // funct3 of the branch group, 3'd2 and 3'd3 reserved
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } branchFunct_e;

  // i-format, used by jalr
  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iFormat_t;

  // b-format, immediate scattered around the register fields
  typedef struct packed {
    logic        imm12;
    logic [5:0]  imm10_5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm4_1;
    logic        imm11;
    logic [6:0]  opcode;
  } bFormat_t;

  // j-format for jal
  typedef struct packed {
    logic        imm20;
    logic [9:0]  imm10_1;
    logic        imm11;
    logic [7:0]  imm19_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } jFormat_t;

  // one instruction word, several readings of the same bits
  typedef union packed {
    logic [31:0] raw;
    iFormat_t    iType;
    bFormat_t    bType;
    jFormat_t    jType;
  } instr_u;

endpackage

//--- pc_cfg.svh
`ifndef PC_CFG_SVH
`define PC_CFG_SVH

// width of data words and instruction addresses
`define PC_XLEN 32

// first fetch address once reset releases
`define PC_RESET_VECTOR 32'h0000_0000

// sequential increment, one 32-bit instruction
`define PC_STEP 32'd4

`endif
